/* bench/sweep_stimulus.txt */
// seed  polynomial  pause_cycle  restart_cycle  stall_mode  expected_word_count
// All hex, cycles count from the start pulse, 0 means none
// Plain full sweep
0123456789abcdef d800000000000000 0 0 0 100
// Same seed, pause held from cycle 40
0123456789abcdef d800000000000000 28 0 0 100
// Random consume, FIFO reaches almost-full
0123456789abcdef d800000000000000 0 0 1 100
// Restart at cycle 60, then a fresh start
fedcba9876543210 d800000000000000 0 3c 0 100
// Other taps
fedcba9876543210 800000000000000d 0 0 0 100
// Pause on top of random stalls
0f1e2d3c4b5a6978 b000000000000001 64 0 1 100
// Restart while the consumer stalls
13579bdf2468ace0 9000000000000a00 0 50 1 100
// Dense taps, early pause
0000000000000001 ffffffffffffffff 10 0 0 100

/* project.f */
+incdir+src
src/sweep_pkg.sv
src/lfsr_internal.sv
src/msg_fifo.sv
src/misr_compactor.sv
src/lfsr_sweep_top.sv
bench/tb_lfsr_sweep.sv

/* Bender.yml */
package:
  name: lfsr_sweep

sources:
  - include_dirs:
      - src
    files:
      - src/sweep_pkg.sv
      - src/lfsr_internal.sv
      - src/msg_fifo.sv
      - src/misr_compactor.sv
      - src/lfsr_sweep_top.sv

  - target: test
    include_dirs:
      - src
    files:
      - bench/tb_lfsr_sweep.sv

/* bench/tb_lfsr_sweep.sv */
`timescale 1ns/1ps
`include "sweep_defines.svh"

// Self-checking bench for the message sweep engine
// Cases come from the stimulus file, signatures from a local reference model
module tb_lfsr_sweep import sweep_pkg::*; ();

    localparam int num_cases    = 8;
    localparam int fields       = 6;                     // Words per case in the file
    localparam int sweep_words  = 1 << `SWEEP_COUNT_W;
    localparam int pause_len    = 6;                     // Cycles a pause is held
    localparam int done_timeout = 4000;                  // Worst case with stalls is far below

    logic clk;
    logic rst_n;
    logic start;
    logic pause;
    logic restart;
    logic consume;
    msg_t message_seed;
    msg_t polynomial;
    sig_t signature;
    logic [`SWEEP_COUNT_W:0] word_count;
    logic sweep_done;
    logic overflow;

    logic [`SWEEP_WORD_W-1:0] stim [num_cases*fields];   // Flat list, six words per case

    integer rand_seed = 59393;
    int     pause_at;     // Cycle after start where pause rises, 0 for none
    int     stall_mode;   // 1 gives random consume

    initial clk = 1'b0;
    always #2 clk = ~clk;   // 4 ns period

    lfsr_sweep_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .pause        (pause),
        .restart      (restart),
        .consume      (consume),
        .message_seed (message_seed),
        .polynomial   (polynomial),
        .signature    (signature),
        .word_count   (word_count),
        .sweep_done   (sweep_done),
        .overflow     (overflow)
    );

    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    // Galois step as a whole-word shift
    // Feedback bit lands on the top bit and on every set tap below it
    function automatic msg_t ref_next_word(input msg_t cur, input msg_t taps);
        msg_t mask;
        mask = {1'b1, taps[`SWEEP_WORD_W-2:0]};
        return cur[0] ? ((cur >> 1) ^ mask) : (cur >> 1);
    endfunction

    function automatic sig_t ref_fold(input sig_t sig, input msg_t word);
        sig_t acc;
        acc = sig << 1;
        if (sig[`SWEEP_WORD_W-1]) begin
            acc = acc ^ `SWEEP_MISR_POLY;   // Top bit dropped out
        end
        return acc ^ word;
    endfunction

    // Whole sweep, seed first, then its successors
    function automatic sig_t ref_signature(input msg_t seed, input msg_t taps);
        msg_t word;
        sig_t sig;
        word = seed;
        sig  = '0;
        for (int i = 0; i < sweep_words; i++) begin
            sig  = ref_fold(sig, word);
            word = ref_next_word(word, taps);
        end
        return sig;
    endfunction

    // One clock of pause and consume stimulus, n counts from the start pulse
    task automatic drive_cycle(input int n);
        integer r;
        r = $random(rand_seed);
        @(posedge clk);
        pause   <= (pause_at != 0) && (n >= pause_at) && (n < pause_at + pause_len);
        consume <= (stall_mode != 0) ? r[0] : 1'b1;
    endtask

    task automatic pulse_restart();
        @(posedge clk);
        restart <= 1'b1;
        pause   <= 1'b0;
        @(posedge clk);
        restart <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;   // Seen in init on the next edge
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_sweep_done(input int idx);
        int n;
        n = 0;
        @(negedge clk);   // Outputs settled here
        while (!sweep_done) begin
            if (n >= done_timeout) begin
                $display("Timeout: sweep_done did not rise within %0d cycles in case %0d",
                         done_timeout, idx);
                stop_run();
            end
            drive_cycle(n);
            n++;
            @(negedge clk);
        end
    endtask

    task automatic check_result(input int idx, input msg_t seed, input msg_t taps,
                                input logic [`SWEEP_WORD_W-1:0] exp_count);
        sig_t exp_sig;
        exp_sig = ref_signature(seed, taps);
        assert (word_count == exp_count && word_count == sweep_words) else begin
            $display("Error at %0t: case %0d word_count %0d, expected %0d",
                     $time, idx, word_count, exp_count);
            stop_run();
        end
        assert (signature == exp_sig) else begin
            $display("Error at %0t: case %0d signature %h, expected %h",
                     $time, idx, signature, exp_sig);
            stop_run();
        end
        assert (!overflow) else begin
            $display("Error at %0t: case %0d overflow set, a word was dropped", $time, idx);
            stop_run();
        end
        $display("Case %0d ok, signature %h", idx, signature);
    endtask

    task automatic run_case(input int idx);
        msg_t seed;
        msg_t taps;
        int   restart_at;
        logic [`SWEEP_WORD_W-1:0] exp_count;
        seed       = stim[idx*fields];
        taps       = stim[idx*fields + 1];
        pause_at   = int'(stim[idx*fields + 2]);
        restart_at = int'(stim[idx*fields + 3]);
        stall_mode = int'(stim[idx*fields + 4]);
        exp_count  = stim[idx*fields + 5];
        @(posedge clk);
        message_seed <= seed;
        polynomial   <= taps;
        consume      <= 1'b1;
        pulse_restart();   // Clears what the previous case left behind
        pulse_start();
        if (restart_at != 0) begin
            for (int n = 0; n < restart_at; n++) begin
                drive_cycle(n);   // Partial sweep, thrown away
            end
            pulse_restart();
            pulse_start();        // Fresh sweep from the same seed
        end
        wait_sweep_done(idx);
        check_result(idx, seed, taps, exp_count);
    endtask

    initial begin
        rst_n        = 1'b0;
        start        = 1'b0;
        pause        = 1'b0;
        restart      = 1'b0;
        consume      = 1'b1;
        message_seed = '0;
        polynomial   = '0;
        pause_at     = 0;
        stall_mode   = 0;
        $readmemh("bench/sweep_stimulus.txt", stim);
        if ($isunknown(stim[0])) begin
            $display("The stimulus file bench/sweep_stimulus.txt could not be read");
            stop_run();
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (word_count == '0 && signature == '0 && !sweep_done && !overflow) else begin
            $display("Error at %0t: outputs not cleared by reset", $time);
            stop_run();
        end
        for (int idx = 0; idx < num_cases; idx++) begin
            run_case(idx);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

/* src/lfsr_sweep_top.sv */
`timescale 1ns/1ps
`include "sweep_defines.svh"

// Message sweep engine
// Generator feeds the FIFO, the compactor drains it into a signature
module lfsr_sweep_top import sweep_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic start,          // Begin a sweep
    input  logic pause,          // Hold the generator
    input  logic restart,        // Abort and clear everything
    input  logic consume,        // Let the compactor drain the FIFO
    input  msg_t message_seed,
    input  msg_t polynomial,
    output sig_t signature,
    output logic [`SWEEP_COUNT_W:0] word_count,
    output logic sweep_done,
    output logic overflow        // A word was lost in the FIFO
);

    // Generator to FIFO
    msg_t gen_word;
    logic gen_valid;
    logic gen_done;
    logic fifo_afull;   // Back-pressure into the generator

    // FIFO to compactor
    msg_t fifo_rd_data;
    logic fifo_empty;
    logic fifo_pop;

    lfsr_internal u_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .pause        (pause),
        .stall        (fifo_afull),
        .restart      (restart),
        .message_seed (message_seed),
        .polynomial   (polynomial),
        .lfsr         (gen_word),
        .valid        (gen_valid),
        .done         (gen_done)
    );

    msg_fifo u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .restart  (restart),
        .push     (gen_valid),   // Valid is the write strobe
        .pop      (fifo_pop),
        .wr_data  (gen_word),
        .rd_data  (fifo_rd_data),
        .empty    (fifo_empty),
        .afull    (fifo_afull),
        .overflow (overflow)
    );

    misr_compactor u_misr (
        .clk        (clk),
        .rst_n      (rst_n),
        .restart    (restart),
        .consume    (consume),
        .empty      (fifo_empty),
        .gen_done   (gen_done),
        .rd_data    (fifo_rd_data),
        .pop        (fifo_pop),
        .sweep_done (sweep_done),
        .signature  (signature),
        .word_count (word_count)
    );

endmodule

/* src/misr_compactor.sv */
`timescale 1ns/1ps
`include "sweep_defines.svh"

// Drains the message FIFO and folds every word into a MISR signature
// Also counts the words and flags the end of the sweep
module misr_compactor import sweep_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic restart,     // Clears signature, count and done
    input  logic consume,     // Consumer allowed to take words
    input  logic empty,       // FIFO has no word
    input  logic gen_done,    // Generator emitted the whole sweep
    input  msg_t rd_data,     // FIFO head word
    output logic pop,
    output logic sweep_done,  // Held once every word has been compacted
    output sig_t signature,
    output logic [`SWEEP_COUNT_W:0] word_count
);

    // One MISR step
    // Shift left, fold in the polynomial when the top bit drops out, then add the word
    function automatic sig_t misr_step(input sig_t cur, input msg_t word);
        sig_t shifted;
        shifted = {cur[`SWEEP_WORD_W-2:0], 1'b0};
        if (cur[`SWEEP_WORD_W-1]) begin
            shifted = shifted ^ `SWEEP_MISR_POLY;
        end
        return shifted ^ word;
    endfunction

    assign pop = consume & ~empty;   // Only pop a word that is there

    always_ff @(posedge clk) begin   // Signature and word count
        if (!rst_n || restart) begin
            signature  <= '0;
            word_count <= '0;
        end else if (pop) begin
            signature  <= misr_step(signature, rd_data);   // Same edge as the pop
            word_count <= word_count + 1'b1;
        end
    end

    // Generator finished and the FIFO drained
    // An empty FIFO leaves no pop pending
    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            sweep_done <= 1'b0;
        end else if (gen_done && empty) begin
            sweep_done <= 1'b1;   // Sticky until restart
        end
    end

endmodule

/* src/msg_fifo.sv */
`timescale 1ns/1ps
`include "sweep_defines.svh"

// Circular message buffer between generator and compactor
// Head word is shown on rd_data, it leaves on the edge where pop is high
module msg_fifo import sweep_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic restart,    // Drops all contents
    input  logic push,       // Write strobe
    input  logic pop,        // Remove head word
    input  msg_t wr_data,
    output msg_t rd_data,    // Head word
    output logic empty,
    output logic afull,      // Fill at or above threshold
    output logic overflow    // Sticky, a push was lost
);

    localparam int ptr_w = $clog2(`SWEEP_FIFO_DEPTH);
    localparam int cnt_w = ptr_w + 1;

    localparam logic [ptr_w-1:0] last_ptr    = ptr_w'(`SWEEP_FIFO_DEPTH - 1);
    localparam logic [cnt_w-1:0] full_level  = cnt_w'(`SWEEP_FIFO_DEPTH);
    localparam logic [cnt_w-1:0] afull_level = cnt_w'(`SWEEP_FIFO_AFULL);

    msg_t mem [`SWEEP_FIFO_DEPTH];   // Storage, no reset

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] fill;

    logic full;
    logic do_push;
    logic do_pop;

    assign full  = (fill == full_level);
    assign empty = (fill == '0);
    assign afull = (fill >= afull_level);

    assign do_pop  = pop & ~empty;
    assign do_push = push & (~full | do_pop);   // A pop in the same cycle frees a slot

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin   // Pointers, fill and overflow
        if (!rst_n || restart) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;   // Both or neither
            endcase
            if (push && !do_push) begin
                overflow <= 1'b1;   // Word dropped
            end
        end
    end

    assign rd_data = mem[rd_ptr];

endmodule

/* src/lfsr_internal.sv */
`timescale 1ns/1ps
`include "sweep_defines.svh"

// Galois LFSR message generator
// Emits the seed and its successors, one word per cycle, for one full sweep
module lfsr_internal import sweep_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic start,          // Begin a sweep, seed and polynomial are valid
    input  logic pause,          // External hold request
    input  logic stall,          // Hold request from FIFO almost-full
    input  logic restart,        // Back to init from any state
    input  msg_t message_seed,   // First word of the sweep
    input  msg_t polynomial,     // Tap mask, bit i feeds stage i
    output msg_t lfsr,           // Current message word
    output logic valid,          // Write strobe for lfsr
    output logic done            // Sweep complete, held until restart
);

    // Counter value of the final word
    localparam logic [`SWEEP_COUNT_W-1:0] last_count = '1;

    gen_state_t state, next_state;

    msg_t lfsr_reg;                            // Shift register
    msg_t poly_reg;                            // Taps captured in init
    logic [`SWEEP_COUNT_W-1:0] counter_reg;    // Words emitted so far

    logic hold;             // Pause and stall treated alike
    logic load_seed_poly;   // Capture seed and taps
    logic step;             // Advance LFSR and counter

    // Right-shifting Galois step
    // Bit 0 is the feedback, it enters every tapped stage and the top bit
    function automatic msg_t galois_step(input msg_t cur, input msg_t taps);
        msg_t nxt;
        logic fb;
        fb = cur[0];
        for (int i = 0; i < `SWEEP_WORD_W - 1; i++) begin
            nxt[i] = taps[i] ? (cur[i+1] ^ fb) : cur[i+1];
        end
        nxt[`SWEEP_WORD_W-1] = fb;
        return nxt;
    endfunction

    assign hold = pause | stall;

    always_ff @(posedge clk) begin   // State register
        if (!rst_n) begin
            state <= st_init;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin   // Next state
        next_state = state;
        if (restart) begin
            next_state = st_init;   // Restart wins from any state
        end else begin
            case (state)
                st_init: begin
                    if (start) begin
                        next_state = st_first;
                    end
                end
                st_first: begin
                    // Seed goes out this cycle whatever happens
                    next_state = hold ? st_paused : st_working;
                end
                st_working: begin
                    if (counter_reg == last_count) begin
                        next_state = st_finished;   // Last word leaves now
                    end else if (hold) begin
                        next_state = st_paused;     // Current word still emitted
                    end
                end
                st_paused: begin
                    if (!hold) begin
                        next_state = st_working;
                    end
                end
                st_finished: begin
                    next_state = st_finished;
                end
                default: begin
                    next_state = st_init;
                end
            endcase
        end
    end

    // Outputs decoded from state only
    assign load_seed_poly = (state == st_init);
    assign valid          = (state == st_first) || (state == st_working);
    assign done           = (state == st_finished);
    assign step           = valid;   // Every emitted word advances the LFSR

    always_ff @(posedge clk) begin   // LFSR datapath
        if (load_seed_poly) begin
            lfsr_reg <= message_seed;
            poly_reg <= polynomial;
        end else if (step) begin
            lfsr_reg <= galois_step(lfsr_reg, poly_reg);
        end
    end

    always_ff @(posedge clk) begin   // Sweep counter
        if (!rst_n) begin
            counter_reg <= '0;
        end else if (load_seed_poly) begin
            counter_reg <= '0;
        end else if (step) begin
            counter_reg <= counter_reg + 1'b1;   // Wraps after the last word, unused then
        end
    end

    assign lfsr = lfsr_reg;

endmodule

/* src/sweep_pkg.sv */
`include "sweep_defines.svh"

package sweep_pkg;

    // One message word as it leaves the generator
    typedef logic [`SWEEP_WORD_W-1:0] msg_t;

    // Compacted signature, same width as a word
    typedef logic [`SWEEP_WORD_W-1:0] sig_t;

    // Generator FSM
    typedef enum logic [2:0] {
        st_init     = 3'h0,  // Seed and polynomial follow the inputs
        st_first    = 3'h1,  // Seed word on the output
        st_working  = 3'h2,  // One new word per cycle
        st_paused   = 3'h3,  // Hold, LFSR frozen
        st_finished = 3'h4   // All words emitted
    } gen_state_t;

endpackage

/* src/sweep_defines.svh */
`ifndef SWEEP_DEFINES_SVH
`define SWEEP_DEFINES_SVH

// Message word width, same as the cipher block width
`define SWEEP_WORD_W 64

// Sweep counter width, a sweep is 2**SWEEP_COUNT_W words
`define SWEEP_COUNT_W 8

// Message FIFO depth in words
`define SWEEP_FIFO_DEPTH 16

// Fill level that raises almost-full
// Leaves headroom for the words still in flight once the generator holds
`define SWEEP_FIFO_AFULL 12

// MISR feedback taps, x^64 + x^4 + x^3 + x + 1
`define SWEEP_MISR_POLY 64'h0000_0000_0000_001B

`endif
